//--- logic/cam_cfg_pkg.sv
`default_nettype none

package cam_cfg_pkg;

   typedef logic [7:0]  dev_addr_t;   // 8-bit form, r/w in bit 0
   typedef logic [15:0] reg_ptr_t;
   typedef logic [7:0]  reg_data_t;

   typedef struct packed {
      logic      is_read;
      dev_addr_t dev_addr;
      reg_ptr_t  reg_ptr;
      reg_data_t data;               // ignored on reads
   } i2c_cmd_t;

   typedef struct packed {
      logic      nack;               // any slave ack missing
      reg_data_t data;               // byte read back
   } i2c_rsp_t;

   typedef struct packed {
      dev_addr_t kind_or_addr;       // device address or DELAY_MARK
      reg_ptr_t  reg_ptr;
      reg_data_t data;               // delay count on delay entries
   } init_entry_t;

   localparam dev_addr_t DELAY_MARK  = 8'hAA;
   localparam dev_addr_t SENSOR_ADDR = 8'h6C;
   localparam reg_ptr_t  CHIP_ID_PTR = 16'h300B;
   localparam int        INIT_LEN    = 24;

   // sensor bring-up, walked front to back
   localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
      {SENSOR_ADDR, 16'h0103, 8'h01},    // software reset
      {DELAY_MARK,  16'h0000, 8'd10},    // let the reset settle
      {SENSOR_ADDR, 16'h0100, 8'h00},    // software standby
      {DELAY_MARK,  16'h0000, 8'd10},
      {SENSOR_ADDR, 16'h3638, 8'hFF},    // analog control
      {SENSOR_ADDR, 16'h0302, 8'd24},    // pll1 multiplier
      {SENSOR_ADDR, 16'h0303, 8'h00},    // pll1 divm
      {SENSOR_ADDR, 16'h0304, 8'h03},    // pll1 mipi divider
      {SENSOR_ADDR, 16'h030E, 8'h00},    // pll2 r_divs
      {SENSOR_ADDR, 16'h030F, 8'h04},
      {SENSOR_ADDR, 16'h0312, 8'h01},    // pll2 pre divider
      {SENSOR_ADDR, 16'h031E, 8'h0C},
      {SENSOR_ADDR, 16'h3808, 8'h02},    // x output size h
      {SENSOR_ADDR, 16'h3809, 8'h80},    // x output size l
      {SENSOR_ADDR, 16'h380A, 8'h01},    // y output size h
      {SENSOR_ADDR, 16'h380B, 8'hE0},    // y output size l
      {SENSOR_ADDR, 16'h4000, 8'hF1},    // blc trigger enables
      {SENSOR_ADDR, 16'h4005, 8'h10},    // blc target
      {SENSOR_ADDR, 16'h4013, 8'hCF},    // manual blc offset
      {DELAY_MARK,  16'h0000, 8'd4},
      {SENSOR_ADDR, 16'h5018, 8'h19},    // red mwb gain
      {SENSOR_ADDR, 16'h501A, 8'h10},    // green mwb gain
      {SENSOR_ADDR, 16'h501C, 8'h17},    // blue mwb gain
      {SENSOR_ADDR, 16'h0100, 8'h01}     // stream on
   };

endpackage

`default_nettype wire

//--- logic/i2c_master.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_master (
   input  wire                        CLK_400K,
   input  wire                        RESET_N,
   input  wire cam_cfg_pkg::i2c_cmd_t cmd,
   input  wire                        cmd_valid,
   output logic                       cmd_ready,
   output cam_cfg_pkg::i2c_rsp_t      rsp,
   output logic                       rsp_valid,
   input  wire                        sda_in,
   output logic                       sda_oe,
   output logic                       scl_out
);

   typedef enum logic [2:0] {
      M_IDLE,
      M_START,
      M_BITS,
      M_STOP,
      M_GAP
   } mst_state_t;

   mst_state_t            state;
   logic [1:0]            phase;       // quarter of the current scl bit
   logic [3:0]            bit_cnt;     // 8 is the ack slot
   logic [1:0]            byte_cnt;
   logic                  second;      // read phase after the repeated start
   logic                  nack_acc;
   cam_cfg_pkg::i2c_cmd_t cmd_q;
   logic [7:0]            shift;
   logic [7:0]            byte_sel;
   logic [1:0]            byte_nxt;
   logic [1:0]            last_byte;
   logic                  accept;
   logic                  slot_end;
   logic                  rd_seg2;
   logic                  rd_byte;
   logic                  load_byte;
   logic                  finish;

   assign accept    = (state == M_IDLE) && cmd_valid && cmd_ready;
   assign cmd_ready = (state == M_IDLE) && !rsp_valid;
   assign slot_end  = (phase == 2'd3);
   assign rd_seg2   = cmd_q.is_read && second;
   assign rd_byte   = rd_seg2 && (byte_cnt == 2'd1);
   // write: addr ptr_h ptr_l data / read: addr ptr_h ptr_l then addr data
   assign last_byte = !cmd_q.is_read ? 2'd3 : (second ? 2'd1 : 2'd2);
   assign byte_nxt  = (state == M_START) ? 2'd0 : byte_cnt + 2'd1;
   assign load_byte = slot_end && ((state == M_START) ||
                      ((state == M_BITS) && (bit_cnt == 4'd8) && (byte_cnt != last_byte)));
   assign finish    = slot_end && (((state == M_STOP) && rd_seg2) ||
                                   ((state == M_GAP) && !cmd_q.is_read));

   always_comb begin
      case (byte_nxt)
         2'd0:    byte_sel = {cmd_q.dev_addr[7:1], second};  // r/w bit set on the read phase
         2'd1:    byte_sel = cmd_q.reg_ptr[15:8];
         2'd2:    byte_sel = cmd_q.reg_ptr[7:0];
         default: byte_sel = cmd_q.data;
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state     <= M_IDLE;
         phase     <= 2'd0;
         bit_cnt   <= 4'd0;
         byte_cnt  <= 2'd0;
         second    <= 1'b0;
         nack_acc  <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= finish;
         phase     <= (state == M_IDLE) ? 2'd0 : phase + 2'd1;
         case (state)
            M_IDLE: begin
               if (accept) begin
                  state    <= M_START;
                  second   <= 1'b0;
                  nack_acc <= 1'b0;
               end
            end
            M_START: begin
               if (slot_end) begin
                  state    <= M_BITS;
                  bit_cnt  <= 4'd0;
                  byte_cnt <= 2'd0;
               end
            end
            M_BITS: begin
               if ((phase == 2'd2) && (bit_cnt == 4'd8) && !rd_byte) begin
                  nack_acc <= nack_acc | sda_in;     // released sda means no ack
               end
               if (slot_end) begin
                  if (bit_cnt != 4'd8) begin
                     bit_cnt <= bit_cnt + 4'd1;
                  end else if (byte_cnt == last_byte) begin
                     state <= M_STOP;
                  end else begin
                     bit_cnt  <= 4'd0;
                     byte_cnt <= byte_cnt + 2'd1;
                  end
               end
            end
            M_STOP: begin
               if (slot_end) begin
                  state <= rd_seg2 ? M_IDLE : M_GAP;
               end
            end
            M_GAP: begin
               if (slot_end) begin
                  if (cmd_q.is_read) begin
                     state  <= M_START;          // repeated start for the data byte
                     second <= 1'b1;
                  end else begin
                     state <= M_IDLE;
                  end
               end
            end
            default: state <= M_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (accept) begin
         cmd_q <= cmd;
      end
      if (load_byte) begin
         shift <= byte_sel;
      end else if ((state == M_BITS) && (bit_cnt != 4'd8)) begin
         if (rd_byte && (phase == 2'd2)) begin
            shift <= {shift[6:0], sda_in};    // sample mid high phase
         end else if (!rd_byte && slot_end) begin
            shift <= {shift[6:0], 1'b0};
         end
      end
      if (finish) begin
         rsp.nack <= nack_acc;
         rsp.data <= shift;
      end
   end

   // scl high in q1 and q2 of a data bit, start and stop move sda while scl is high
   always_comb begin
      scl_out = 1'b1;
      sda_oe  = 1'b0;
      case (state)
         M_START: begin
            scl_out = (phase != 2'd3);
            sda_oe  = phase[1];
         end
         M_BITS: begin
            scl_out = phase[0] ^ phase[1];
            sda_oe  = (bit_cnt != 4'd8) && !rd_byte && !shift[7];
         end
         M_STOP: begin
            scl_out = (phase != 2'd0);
            sda_oe  = !phase[1];
         end
         default: begin
            scl_out = 1'b1;                   // idle and bus free slot
            sda_oe  = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/cam_init_seq.sv
`timescale 1ns/1ns
`default_nettype none

module cam_init_seq #(
   parameter logic [7:0]  EXPECTED_ID = 8'h88,
   parameter logic [15:0] DELAY_UNIT  = 16'd40,
   parameter logic [7:0]  RETRY_GAP   = 8'd6
) (
   input  wire                        CLK_400K,
   input  wire                        RESET_N,
   output cam_cfg_pkg::i2c_cmd_t      cmd,
   output logic                       cmd_valid,
   input  wire                        cmd_ready,
   input  wire cam_cfg_pkg::i2c_rsp_t rsp,
   input  wire                        rsp_valid,
   output cam_cfg_pkg::reg_data_t     chip_id,
   output logic                       camera_release
);

   localparam int IDX_W = $clog2(cam_cfg_pkg::INIT_LEN);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(cam_cfg_pkg::INIT_LEN - 1);

   typedef enum logic [2:0] {
      ST_ID_GAP,
      ST_ID_REQ,
      ST_ID_WAIT,
      ST_DISPATCH,
      ST_WR_REQ,
      ST_WR_WAIT,
      ST_DONE
   } seq_state_t;

   seq_state_t               state;
   logic [IDX_W-1:0]         idx;
   logic [7:0]               gap_cnt;
   logic [23:0]              dly_cnt;
   logic [23:0]              dly_len;
   cam_cfg_pkg::init_entry_t cur;
   logic                     is_delay;
   logic                     id_ok;

   assign cur      = cam_cfg_pkg::INIT_TABLE[idx];
   assign is_delay = (cur.kind_or_addr == cam_cfg_pkg::DELAY_MARK);
   assign dly_len  = cur.data * DELAY_UNIT;
   assign id_ok    = !rsp.nack && (rsp.data == EXPECTED_ID);

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state          <= ST_ID_GAP;      // short settle before the first id read
         idx            <= '0;
         gap_cnt        <= 8'd0;
         dly_cnt        <= 24'd0;
         cmd_valid      <= 1'b0;
         chip_id        <= '0;
         camera_release <= 1'b0;
      end else begin
         case (state)
            ST_ID_GAP: begin
               gap_cnt <= gap_cnt + 8'd1;
               if (gap_cnt + 8'd1 >= RETRY_GAP) begin
                  cmd_valid <= 1'b1;
                  state     <= ST_ID_REQ;
               end
            end
            ST_ID_REQ: begin
               if (cmd_ready) begin
                  cmd_valid <= 1'b0;
                  state     <= ST_ID_WAIT;
               end
            end
            ST_ID_WAIT: begin
               if (rsp_valid) begin
                  if (id_ok) begin
                     chip_id <= rsp.data;
                     state   <= ST_DISPATCH;
                  end else begin
                     gap_cnt <= 8'd0;         // wrong id or no ack, read again
                     state   <= ST_ID_GAP;
                  end
               end
            end
            ST_DISPATCH: begin
               if (!is_delay) begin
                  cmd_valid <= 1'b1;
                  state     <= ST_WR_REQ;
               end else if (dly_cnt + 24'd2 >= dly_len) begin
                  dly_cnt <= 24'd0;           // one more dispatch cycle ends the wait
                  idx     <= idx + 1'b1;
               end else begin
                  dly_cnt <= dly_cnt + 24'd1;
               end
            end
            ST_WR_REQ: begin
               if (cmd_ready) begin
                  cmd_valid <= 1'b0;
                  state     <= ST_WR_WAIT;
               end
            end
            ST_WR_WAIT: begin
               if (rsp_valid) begin
                  if (rsp.nack) begin
                     state <= ST_DISPATCH;    // same entry again
                  end else if (idx == LAST_IDX) begin
                     camera_release <= 1'b1;
                     state          <= ST_DONE;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= ST_DISPATCH;
                  end
               end
            end
            ST_DONE: begin
               camera_release <= 1'b1;        // parked until reset
            end
            default: state <= ST_ID_GAP;
         endcase
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (state == ST_ID_GAP) begin
         cmd <= '{1'b1, cam_cfg_pkg::SENSOR_ADDR, cam_cfg_pkg::CHIP_ID_PTR, 8'h00};
      end else if (state == ST_DISPATCH) begin
         cmd <= '{1'b0, cur.kind_or_addr, cur.reg_ptr, cur.data};
      end
   end

endmodule

`default_nettype wire

//--- logic/cam_config_top.sv
`timescale 1ns/1ns
`default_nettype none

module cam_config_top #(
   parameter logic [7:0]  EXPECTED_ID = 8'h88,
   parameter logic [15:0] DELAY_UNIT  = 16'd40,
   parameter logic [7:0]  RETRY_GAP   = 8'd6
) (
   input  wire                    CLK_400K,
   input  wire                    RESET_N,
   output logic                   i2c_scl,
   inout  wire                    i2c_sda,
   output cam_cfg_pkg::reg_data_t chip_id,
   output logic                   camera_release
);

   cam_cfg_pkg::i2c_cmd_t cmd;
   logic                  cmd_valid;
   logic                  cmd_ready;
   cam_cfg_pkg::i2c_rsp_t rsp;
   logic                  rsp_valid;
   logic                  sda_oe;
   wire                   sda_in;

   assign i2c_sda = sda_oe ? 1'b0 : 1'bz;   // open drain, pull-up off chip
   assign sda_in  = i2c_sda;

   cam_init_seq #(
      .EXPECTED_ID (EXPECTED_ID),
      .DELAY_UNIT  (DELAY_UNIT),
      .RETRY_GAP   (RETRY_GAP)
   ) cam_init_seq_i (
      .CLK_400K       (CLK_400K),
      .RESET_N        (RESET_N),
      .cmd            (cmd),
      .cmd_valid      (cmd_valid),
      .cmd_ready      (cmd_ready),
      .rsp            (rsp),
      .rsp_valid      (rsp_valid),
      .chip_id        (chip_id),
      .camera_release (camera_release)
   );

   i2c_master i2c_master_i (
      .CLK_400K  (CLK_400K),
      .RESET_N   (RESET_N),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .sda_in    (sda_in),
      .sda_oe    (sda_oe),
      .scl_out   (i2c_scl)                 // push-pull scl
   );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS   = 20,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;                        // released on a falling edge
   end

endmodule

`default_nettype wire

//--- dv/i2c_sensor_model.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_sensor_model #(
   parameter logic [7:0] CHIP_ID = 8'h88
) (
   input  wire         scl,
   inout  wire         sda,
   input  wire  [1:0]  wrong_ids,        // wrong chip-id replies before the right one
   input  wire  [4:0]  nack_at,          // write that is refused once
   output logic [15:0] wr_count,
   output logic [7:0]  wr_addr,
   output logic [15:0] wr_ptr,
   output logic [7:0]  wr_data,
   output logic        wr_acked,
   output logic [63:0] wr_start_t,
   output logic [63:0] prev_stop_t,
   output logic [15:0] rd_count,
   output logic [7:0]  rd_addr,
   output logic [15:0] rd_ptr,
   output logic        id_given
);

   logic        sda_drv;
   logic        active;
   logic        skip_neg;              // scl fall that ends the start condition
   logic        sending;
   logic        send_next;
   logic        acks_ok;
   logic        ack;
   logic        nack_done;
   logic [3:0]  bit_pos;               // 8 is the ack slot
   logic [2:0]  byte_no;
   logic [7:0]  sh;
   logic [7:0]  tx;
   logic [7:0]  addr_q;
   logic [15:0] ptr_q;
   logic [7:0]  data_q;
   logic [15:0] acked_writes;
   logic [63:0] xfer_start_t;
   logic [63:0] last_stop_t;

   assign sda = sda_drv ? 1'b0 : 1'bz;

   initial begin
      sda_drv      = 1'b0;
      active       = 1'b0;
      nack_done    = 1'b0;
      id_given     = 1'b0;
      wr_count     = '0;
      rd_count     = '0;
      acked_writes = '0;
      last_stop_t  = '0;
   end

   // start and repeated start
   always @(negedge sda) begin
      if (scl === 1'b1) begin
         active       = 1'b1;
         skip_neg     = 1'b1;
         sending      = 1'b0;
         send_next    = 1'b0;
         acks_ok      = 1'b1;
         bit_pos      = 4'd0;
         byte_no      = 3'd0;
         xfer_start_t = $time;
      end
   end

   // stop, log what the transaction did
   always @(posedge sda) begin
      if (scl === 1'b1) begin
         if (active && !addr_q[0] && byte_no == 3'd4) begin
            wr_addr     = addr_q;
            wr_ptr      = ptr_q;
            wr_data     = data_q;
            wr_acked    = acks_ok;
            wr_start_t  = xfer_start_t;
            prev_stop_t = last_stop_t;
            if (acks_ok) acked_writes = acked_writes + 16'd1;
            wr_count = wr_count + 16'd1;
         end else if (active && addr_q[0] && byte_no == 3'd2) begin
            rd_addr  = addr_q;
            rd_ptr   = ptr_q;
            rd_count = rd_count + 16'd1;
         end
         active      = 1'b0;
         last_stop_t = $time;
      end
   end

   always @(posedge scl) begin
      if (active && !sending && bit_pos < 4'd8) sh = {sh[6:0], sda};
   end

   always @(negedge scl) begin
      if (active) begin
         if (skip_neg) begin
            skip_neg = 1'b0;
         end else if (bit_pos < 4'd7) begin
            bit_pos = bit_pos + 4'd1;
            if (sending) sda_drv = !tx[4'd7 - bit_pos];
         end else if (bit_pos == 4'd7) begin
            bit_pos = 4'd8;
            if (sending) begin
               sda_drv = 1'b0;             // master answers this byte
            end else begin
               ack = 1'b1;
               case (byte_no)
                  3'd0: begin
                     addr_q = sh;
                     ack    = (sh[7:1] == 7'h36);
                     if (sh[0] && ack) begin
                        tx        = (rd_count < wrong_ids) ? (CHIP_ID ^ 8'h5A) : CHIP_ID;
                        send_next = 1'b1;
                        if (tx == CHIP_ID) id_given = 1'b1;
                     end
                  end
                  3'd1: ptr_q[15:8] = sh;
                  3'd2: ptr_q[7:0]  = sh;
                  default: begin
                     data_q = sh;
                     if (acked_writes == 16'(nack_at) && !nack_done) begin
                        ack       = 1'b0;
                        nack_done = 1'b1;
                     end
                  end
               endcase
               acks_ok = acks_ok & ack;
               sda_drv = ack;
            end
            byte_no = byte_no + 3'd1;
         end else begin
            bit_pos = 4'd0;
            sda_drv = 1'b0;
            if (send_next) begin
               sending   = 1'b1;
               send_next = 1'b0;
               sda_drv   = !tx[7];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- dv/cam_config_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cam_config_checker #(
   parameter logic [7:0] EXPECTED_ID = 8'h88,
   parameter int         DELAY_UNIT  = 40,
   parameter int         CLK_NS      = 20
) (
   input  wire         clk,
   input  wire         rst_n,
   input  wire         scl,
   input  wire         sda,
   input  wire  [7:0]  chip_id,
   input  wire         camera_release,
   input  wire  [1:0]  wrong_ids,
   input  wire  [4:0]  nack_at,
   input  wire  [15:0] wr_count,
   input  wire  [7:0]  wr_addr,
   input  wire  [15:0] wr_ptr,
   input  wire  [7:0]  wr_data,
   input  wire         wr_acked,
   input  wire  [63:0] wr_start_t,
   input  wire  [63:0] prev_stop_t,
   input  wire  [15:0] rd_count,
   input  wire  [7:0]  rd_addr,
   input  wire  [15:0] rd_ptr,
   input  wire         id_given,
   input  wire         report_req,
   output logic        report_done,
   output int          errors,
   output int          failed_tests
);

   typedef struct packed {
      logic [15:0] ptr;
      logic [7:0]  data;
      logic [31:0] min_gap;              // cycles from the previous stop
   } exp_wr_t;

   int      err_b [1:5];
   int      k;
   int      nack_seen;
   int      nacked_k;
   int      gap;
   logic    tried;
   logic    rel_seen;
   exp_wr_t exp_wr;
   logic [15:0] wr_seen;
   logic [15:0] rd_seen;

   function automatic int ordinary_count();
      int n;
      n = 0;
      for (int i = 0; i < cam_cfg_pkg::INIT_LEN; i++) begin
         if (cam_cfg_pkg::INIT_TABLE[i].kind_or_addr != cam_cfg_pkg::DELAY_MARK) n++;
      end
      return n;
   endfunction

   // k-th bus write expected from the table, with the delay owed before it
   function automatic exp_wr_t expected_write(int idx);
      exp_wr_t e;
      int      seen;
      int      dly;
      e    = '0;
      seen = 0;
      dly  = 0;
      for (int i = 0; i < cam_cfg_pkg::INIT_LEN; i++) begin
         if (cam_cfg_pkg::INIT_TABLE[i].kind_or_addr == cam_cfg_pkg::DELAY_MARK) begin
            dly += cam_cfg_pkg::INIT_TABLE[i].data;
         end else begin
            if (seen == idx) begin
               e.ptr     = cam_cfg_pkg::INIT_TABLE[i].reg_ptr;
               e.data    = cam_cfg_pkg::INIT_TABLE[i].data;
               e.min_gap = 32'(dly * DELAY_UNIT);
               return e;
            end
            seen++;
            dly = 0;
         end
      end
      return e;
   endfunction

   task automatic flag_value(input int b, input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      err_b[b]++;
      errors++;
   endtask

   initial begin
      for (int i = 1; i <= 5; i++) err_b[i] = 0;
      errors       = 0;
      failed_tests = 0;
      report_done  = 1'b0;
      k            = 0;
      nack_seen    = 0;
      nacked_k     = -1;
      tried        = 1'b0;
      rel_seen     = 1'b0;
      wr_seen      = '0;
      rd_seen      = '0;
   end

   always @(posedge clk) begin
      if (rst_n) begin
         if (rd_count != rd_seen) begin
            rd_seen = rd_count;
            if (rd_addr != (cam_cfg_pkg::SENSOR_ADDR | 8'h01) ||
                rd_ptr != cam_cfg_pkg::CHIP_ID_PTR)
               flag_value(1, $sformatf("id read went to %h/%h", rd_addr, rd_ptr));
         end
         if (wr_count != wr_seen) begin
            wr_seen = wr_count;
            if (!id_given) flag_value(1, "register write before the chip id matched");
            if (k >= ordinary_count()) begin
               flag_value(3, $sformatf("extra write %h <- %h", wr_ptr, wr_data));
            end else begin
               exp_wr = expected_write(k);
               if (!tried) begin
                  gap = int'((wr_start_t - prev_stop_t) / CLK_NS);
                  if (gap < int'(exp_wr.min_gap))
                     flag_value(4, $sformatf("write %0d gap %0d < %0d", k, gap, exp_wr.min_gap));
                  tried = 1'b1;
               end
               if (wr_addr != cam_cfg_pkg::SENSOR_ADDR || wr_ptr != exp_wr.ptr ||
                   wr_data != exp_wr.data)
                  flag_value(3, $sformatf("write %0d got %h:%h<-%h, want %h<-%h", k,
                                          wr_addr, wr_ptr, wr_data, exp_wr.ptr, exp_wr.data));
               if (wr_acked) begin
                  k++;
                  tried = 1'b0;
               end else begin
                  nack_seen++;
                  nacked_k = k;
               end
            end
         end
         if (camera_release && !rel_seen) begin
            rel_seen = 1'b1;
            if (k != ordinary_count())
               flag_value(5, $sformatf("release after only %0d acked writes", k));
            if (chip_id != EXPECTED_ID)
               flag_value(2, $sformatf("chip_id %h, want %h", chip_id, EXPECTED_ID));
            if (rd_count != 16'(wrong_ids) + 16'd1)
               flag_value(2, $sformatf("%0d id reads, want %0d", rd_count, wrong_ids + 1));
         end else if (rel_seen) begin
            if (!camera_release) flag_value(5, "camera_release dropped");
            if (scl !== 1'b1 || sda !== 1'b1) flag_value(5, "bus not idle after release");
         end
      end
   end

   always @(posedge clk) begin
      if (report_req && !report_done) begin
         if (nack_seen != 1 || nacked_k != int'(nack_at))
            flag_value(3, $sformatf("%0d nacked writes, last at %0d, want 1 at %0d",
                                    nack_seen, nacked_k, nack_at));
         $display("test 1 id read addressing: %s", err_b[1] == 0 ? "ok" : "failed");
         $display("test 2 chip id and retries: %s", err_b[2] == 0 ? "ok" : "failed");
         $display("test 3 write sequence: %s", err_b[3] == 0 ? "ok" : "failed");
         $display("test 4 delay gaps: %s", err_b[4] == 0 ? "ok" : "failed");
         $display("test 5 release and idle bus: %s", err_b[5] == 0 ? "ok" : "failed");
         for (int i = 1; i <= 5; i++) begin
            if (err_b[i] != 0) failed_tests++;
         end
         report_done <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- dv/cam_config_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cam_config_tb;

   localparam logic [7:0]  EXPECTED_ID = 8'h88;
   localparam logic [15:0] DELAY_UNIT  = 16'd40;
   localparam logic [7:0]  RETRY_GAP   = 8'd6;
   localparam int          CLK_NS      = 20;
   localparam int          IDLE_TAIL   = 100;   // cycles watched after release

   wire         clk;
   wire         rst_n;
   wire         i2c_scl;
   wire         i2c_sda;
   wire [7:0]   chip_id;
   wire         camera_release;
   wire [15:0]  wr_count;
   wire [7:0]   wr_addr;
   wire [15:0]  wr_ptr;
   wire [7:0]   wr_data;
   wire         wr_acked;
   wire [63:0]  wr_start_t;
   wire [63:0]  prev_stop_t;
   wire [15:0]  rd_count;
   wire [7:0]   rd_addr;
   wire [15:0]  rd_ptr;
   wire         id_given;
   wire         report_done;
   int          errors;
   int          failed_tests;
   logic [31:0] lfsr;
   logic [1:0]  wrong_ids;
   logic [4:0]  nack_at;
   logic        report_req;

   pullup (i2c_sda);

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      repeat (n) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) tb_clock_gen_i (
      .clk   (clk),
      .rst_n (rst_n)
   );

   cam_config_top #(
      .EXPECTED_ID (EXPECTED_ID),
      .DELAY_UNIT  (DELAY_UNIT),
      .RETRY_GAP   (RETRY_GAP)
   ) cam_config_top_i (
      .CLK_400K       (clk),
      .RESET_N        (rst_n),
      .i2c_scl        (i2c_scl),
      .i2c_sda        (i2c_sda),
      .chip_id        (chip_id),
      .camera_release (camera_release)
   );

   i2c_sensor_model #(.CHIP_ID(EXPECTED_ID)) i2c_sensor_model_i (
      .scl (i2c_scl), .sda (i2c_sda), .wrong_ids (wrong_ids), .nack_at (nack_at),
      .wr_count (wr_count), .wr_addr (wr_addr), .wr_ptr (wr_ptr), .wr_data (wr_data),
      .wr_acked (wr_acked), .wr_start_t (wr_start_t), .prev_stop_t (prev_stop_t),
      .rd_count (rd_count), .rd_addr (rd_addr), .rd_ptr (rd_ptr), .id_given (id_given)
   );

   cam_config_checker #(
      .EXPECTED_ID (EXPECTED_ID),
      .DELAY_UNIT  (int'(DELAY_UNIT)),
      .CLK_NS      (CLK_NS)
   ) cam_config_checker_i (
      .clk (clk), .rst_n (rst_n), .scl (i2c_scl), .sda (i2c_sda),
      .chip_id (chip_id), .camera_release (camera_release),
      .wrong_ids (wrong_ids), .nack_at (nack_at),
      .wr_count (wr_count), .wr_addr (wr_addr), .wr_ptr (wr_ptr), .wr_data (wr_data),
      .wr_acked (wr_acked), .wr_start_t (wr_start_t), .prev_stop_t (prev_stop_t),
      .rd_count (rd_count), .rd_addr (rd_addr), .rd_ptr (rd_ptr), .id_given (id_given),
      .report_req (report_req), .report_done (report_done),
      .errors (errors), .failed_tests (failed_tests)
   );

   initial begin
      logic [31:0] v;
      int          writes;
      int          dly_sum;
      int          limit;
      int          cycles;
      lfsr       = 32'hd0def1b9;
      wrong_ids  = 2'd0;
      nack_at    = 5'd0;
      report_req = 1'b0;
      writes     = 0;
      dly_sum    = 0;
      for (int i = 0; i < cam_cfg_pkg::INIT_LEN; i++) begin
         if (cam_cfg_pkg::INIT_TABLE[i].kind_or_addr == cam_cfg_pkg::DELAY_MARK)
            dly_sum += cam_cfg_pkg::INIT_TABLE[i].data;
         else
            writes++;
      end
      // worst case is three wrong ids plus one retried write
      limit = 2 * (4 * (200 + RETRY_GAP) + (writes + 1) * 121 + dly_sum * DELAY_UNIT);
      @(posedge clk);
      @(negedge clk);
      take_bits(2, v);
      wrong_ids = v[1:0];
      take_bits(5, v);
      nack_at = 5'(v % writes);
      $display("wrong id replies %0d, nacked write %0d, limit %0d cycles",
               wrong_ids, nack_at, limit);
      cycles = 0;
      while (camera_release !== 1'b1 && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (camera_release !== 1'b1) begin
         $display("timeout: the configuration never finished within %0d cycles", limit);
         $display("** FAIL **");
         $finish;
      end else begin
         repeat (IDLE_TAIL) @(negedge clk);
         report_req = 1'b1;
         while (!report_done) @(negedge clk);
         $display("tests: %0d passed, %0d failed, %0d errors",
                  5 - failed_tests, failed_tests, errors);
         if (errors == 0) begin
            $display("** PASS **");
         end else begin
            $display("** FAIL **");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- verilog.f
logic/cam_cfg_pkg.sv
logic/i2c_master.sv
logic/cam_init_seq.sv
logic/cam_config_top.sv
dv/tb_clock_gen.sv
dv/i2c_sensor_model.sv
dv/cam_config_checker.sv
dv/cam_config_tb.sv

//--- Bender.yml
package:
  name: cam_config

sources:
  - logic/cam_cfg_pkg.sv
  - logic/i2c_master.sv
  - logic/cam_init_seq.sv
  - logic/cam_config_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/i2c_sensor_model.sv
      - dv/cam_config_checker.sv
      - dv/cam_config_tb.sv
